// ==== cpu_sys.f ====
design/cpu_pkg.sv
design/reg_file.sv
design/internal_rom.sv
design/core.sv
design/data_cache.sv
design/cpu.sv
verif/bus_memory_model.sv
verif/cpu_tb.sv

// ==== design/core.sv ====
`timescale 1ns/10ps

module core (
   input  logic        clk_i,
   input  logic        rst_i,

   input  logic [31:0] instr_cache_data_i,
   output logic [31:2] instr_cache_address_o,

   input  logic [31:0] data_cache_data_i,
   output logic [31:0] data_cache_data_o,
   output logic [31:2] data_cache_address_o,
   output logic        data_cache_read_en_o,
   output logic [3:0]  data_cache_write_en_o,
   input  logic        data_cache_blocking_n_i
);

   logic [1:0]        state_q;
   logic [31:0]       pc_q;
   cpu_pkg::instr_u   instr_q;

   logic [31:0]       rs1_data;
   logic [31:0]       rs2_data;
   logic [31:0]       imm_i, imm_s, imm_b, imm_u, imm_j;

   cpu_pkg::alu_sel_e alu_sel;
   logic [31:0]       alu_b;
   logic [31:0]       alu_result;
   logic              wb_en;
   logic              is_load, is_store, is_beq, is_jal;

   logic [31:0]       link_pc;
   logic [31:0]       next_pc;
   logic              rf_we;
   logic [31:0]       rf_wdata;

   // immediates for every format, picked by the decoder
   assign imm_i = {{20{instr_q.i_fmt.imm[11]}}, instr_q.i_fmt.imm};
   assign imm_s = {{20{instr_q.s_fmt.imm_hi[6]}}, instr_q.s_fmt.imm_hi, instr_q.s_fmt.imm_lo};
   assign imm_b = {{20{instr_q.s_fmt.imm_hi[6]}}, instr_q.s_fmt.imm_lo[0],
                   instr_q.s_fmt.imm_hi[5:0], instr_q.s_fmt.imm_lo[4:1], 1'b0};
   assign imm_u = {instr_q.u_fmt.imm, 12'b0};
   assign imm_j = {{12{instr_q.u_fmt.imm[19]}}, instr_q.u_fmt.imm[7:0],
                   instr_q.u_fmt.imm[8], instr_q.u_fmt.imm[18:9], 1'b0};

   always_comb begin
      alu_sel  = cpu_pkg::ALU_ADD;
      alu_b    = rs2_data;
      wb_en    = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      is_beq   = 1'b0;
      is_jal   = 1'b0;
      case (instr_q.r_fmt.opcode)
         cpu_pkg::OP_LUI: begin
            alu_sel = cpu_pkg::ALU_PASS_B;
            alu_b   = imm_u;
            wb_en   = 1'b1;
         end
         cpu_pkg::OP_OP_IMM: begin
            alu_b = imm_i;
            wb_en = (instr_q.i_fmt.funct3 == 3'b000);
         end
         cpu_pkg::OP_OP: begin
            if (instr_q.r_fmt.funct7[5]) begin
               alu_sel = cpu_pkg::ALU_SUB;
            end
            wb_en = (instr_q.r_fmt.funct3 == 3'b000);
         end
         cpu_pkg::OP_LOAD: begin
            alu_b   = imm_i;
            is_load = 1'b1;
         end
         cpu_pkg::OP_STORE: begin
            alu_b    = imm_s;
            is_store = 1'b1;
         end
         // beq compares through the subtractor
         cpu_pkg::OP_BRANCH: begin
            alu_sel = cpu_pkg::ALU_SUB;
            is_beq  = (instr_q.s_fmt.funct3 == 3'b000);
         end
         cpu_pkg::OP_JAL: begin
            wb_en  = 1'b1;
            is_jal = 1'b1;
         end
         default: begin
            wb_en = 1'b0;
         end
      endcase
   end

   always_comb begin
      case (alu_sel)
         cpu_pkg::ALU_SUB:    alu_result = rs1_data - alu_b;
         cpu_pkg::ALU_PASS_B: alu_result = alu_b;
         default:             alu_result = rs1_data + alu_b;
      endcase
   end

   assign link_pc = pc_q + 32'd4;
   assign next_pc = is_jal ? pc_q + imm_j :
                    (is_beq && alu_result == 32'd0) ? pc_q + imm_b : link_pc;

   // load data lands in the memory state once the cache stops blocking
   assign rf_we = (state_q == cpu_pkg::CORE_EXEC && wb_en) ||
                  (state_q == cpu_pkg::CORE_MEM && is_load && data_cache_blocking_n_i);
   assign rf_wdata = (state_q == cpu_pkg::CORE_MEM) ? data_cache_data_i :
                     is_jal ? link_pc : alu_result;

   assign instr_cache_address_o = pc_q[31:2];
   assign data_cache_address_o  = alu_result[31:2];
   assign data_cache_data_o     = rs2_data;
   assign data_cache_read_en_o  = (state_q == cpu_pkg::CORE_EXEC) && is_load;
   assign data_cache_write_en_o = ((state_q == cpu_pkg::CORE_EXEC) && is_store) ? 4'hf : 4'h0;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= cpu_pkg::CORE_FETCH;
         pc_q    <= 32'd0;
      end else begin
         case (state_q)
            cpu_pkg::CORE_FETCH: state_q <= cpu_pkg::CORE_EXEC;
            cpu_pkg::CORE_EXEC: begin
               if (is_load || is_store) begin
                  state_q <= cpu_pkg::CORE_MEM;
               end else begin
                  pc_q    <= next_pc;
                  state_q <= cpu_pkg::CORE_FETCH;
               end
            end
            cpu_pkg::CORE_MEM: begin
               if (data_cache_blocking_n_i) begin
                  pc_q    <= link_pc;
                  state_q <= cpu_pkg::CORE_FETCH;
               end
            end
            default: state_q <= cpu_pkg::CORE_FETCH;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == cpu_pkg::CORE_FETCH) begin
         instr_q <= instr_cache_data_i;
      end
   end

   reg_file rf0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rs1_i      (instr_q.r_fmt.rs1),
      .rs2_i      (instr_q.r_fmt.rs2),
      .rd_i       (instr_q.r_fmt.rd),
      .rd_data_i  (rf_wdata),
      .rd_we_i    (rf_we),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/10ps

module cpu (
   input  logic clk_i,
   input  logic rst_i,

   output logic [cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT] bus_addr_o,
   output logic [cpu_pkg::BUS_DATA_WIDTH-1:0] bus_data_o,
   output logic bus_we_o,
   output logic bus_valid_o,

   input  logic [cpu_pkg::BUS_DATA_WIDTH-1:0] bus_data_i,
   input  logic bus_valid_i
);

   logic [31:2] icache_address;
   logic [31:0] rom_data;

   logic [31:2] dcache_address;
   logic [31:0] dcache_data_r;
   logic [31:0] dcache_data_w;
   logic        dcache_read_en;
   logic [3:0]  dcache_write_en;
   logic        dcache_blocking_n;

   core core0 (
      .clk_i                   (clk_i),
      .rst_i                   (rst_i),
      .instr_cache_data_i      (rom_data),
      .instr_cache_address_o   (icache_address),
      .data_cache_data_i       (dcache_data_r),
      .data_cache_data_o       (dcache_data_w),
      .data_cache_address_o    (dcache_address),
      .data_cache_read_en_o    (dcache_read_en),
      .data_cache_write_en_o   (dcache_write_en),
      .data_cache_blocking_n_i (dcache_blocking_n)
   );

   // instructions always come from the rom, indexed by word
   internal_rom rom0 (
      .address_i (icache_address[cpu_pkg::ROM_DEPTH_BITS+1:2]),
      .data_o    (rom_data)
   );

   data_cache dcache0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .addr_i       (dcache_address),
      .data_i       (dcache_data_w),
      .read_en_i    (dcache_read_en),
      .write_en_i   (dcache_write_en),
      .data_o       (dcache_data_r),
      .blocking_n_o (dcache_blocking_n),
      .bus_addr_o   (bus_addr_o),
      .bus_data_o   (bus_data_o),
      .bus_we_o     (bus_we_o),
      .bus_valid_o  (bus_valid_o),
      .bus_data_i   (bus_data_i),
      .bus_valid_i  (bus_valid_i)
   );

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

   // external line bus
   localparam int BUS_ADDRESS_WIDTH    = 20;
   localparam int BUS_DATA_WIDTH_SHIFT = 4;
   localparam int BUS_DATA_WIDTH       = (2 ** BUS_DATA_WIDTH_SHIFT) * 8;

   // data cache geometry, four lines
   localparam int DCACHE_INDEX_BITS = 2;
   localparam int DCACHE_TAG_BITS   =
      BUS_ADDRESS_WIDTH - DCACHE_INDEX_BITS - BUS_DATA_WIDTH_SHIFT;

   localparam int ROM_DEPTH_BITS = 5;

   // rv32i major opcodes
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_OP     = 7'b0110011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   // core sequencer states
   localparam logic [1:0] CORE_FETCH = 2'd0;
   localparam logic [1:0] CORE_EXEC  = 2'd1;
   localparam logic [1:0] CORE_MEM   = 2'd2;

   // data cache bus sequencer states
   localparam logic [1:0] DC_IDLE  = 2'd0;
   localparam logic [1:0] DC_FILL  = 2'd1;
   localparam logic [1:0] DC_WRITE = 2'd2;
   localparam logic [1:0] DC_DONE  = 2'd3;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_PASS_B
   } alu_sel_e;

   // one instruction word seen through each encoding format
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r_fmt;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i_fmt;
      // branches share this layout with the bits of the offset shuffled
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s_fmt;
      // also carries the raw jal offset bits
      struct packed {
         logic [19:0] imm;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u_fmt;
   } instr_u;

endpackage

// ==== design/data_cache.sv ====
`timescale 1ns/10ps

module data_cache (
   input  logic        clk_i,
   input  logic        rst_i,

   input  logic [31:2] addr_i,
   input  logic [31:0] data_i,
   input  logic        read_en_i,
   input  logic [3:0]  write_en_i,
   output logic [31:0] data_o,
   output logic        blocking_n_o,

   output logic [cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT] bus_addr_o,
   output logic [cpu_pkg::BUS_DATA_WIDTH-1:0] bus_data_o,
   output logic        bus_we_o,
   output logic        bus_valid_o,
   input  logic [cpu_pkg::BUS_DATA_WIDTH-1:0] bus_data_i,
   input  logic        bus_valid_i
);

   logic [cpu_pkg::BUS_DATA_WIDTH-1:0]         lines_q [2**cpu_pkg::DCACHE_INDEX_BITS];
   logic [cpu_pkg::DCACHE_TAG_BITS-1:0]        tags_q  [2**cpu_pkg::DCACHE_INDEX_BITS];
   logic [2**cpu_pkg::DCACHE_INDEX_BITS-1:0]   valid_q;
   logic [1:0]                                 state_q;

   logic [cpu_pkg::DCACHE_INDEX_BITS-1:0]      req_index, req_index_q;
   logic [cpu_pkg::DCACHE_TAG_BITS-1:0]        req_tag, req_tag_q;
   logic [cpu_pkg::BUS_DATA_WIDTH_SHIFT-3:0]   req_word, req_word_q;
   logic [31:0]                                req_data_q;
   logic                                       req_store_q;

   logic                                       store_req, req_valid, hit, fill_done;
   logic [cpu_pkg::BUS_DATA_WIDTH-1:0]         hit_line, hit_merged, fill_line;

   function automatic logic [cpu_pkg::BUS_DATA_WIDTH-1:0] merge_word(
      input logic [cpu_pkg::BUS_DATA_WIDTH-1:0]       line,
      input logic [cpu_pkg::BUS_DATA_WIDTH_SHIFT-3:0] word,
      input logic [31:0]                              data
   );
      logic [cpu_pkg::BUS_DATA_WIDTH-1:0] merged;
      merged = line;
      merged[word*32 +: 32] = data;
      return merged;
   endfunction

   // index xor-folds the two lowest line-address bit pairs, so lines 0x001 and 0x004 collide
   assign req_index = addr_i[cpu_pkg::BUS_DATA_WIDTH_SHIFT +: cpu_pkg::DCACHE_INDEX_BITS] ^
                      addr_i[cpu_pkg::BUS_DATA_WIDTH_SHIFT + cpu_pkg::DCACHE_INDEX_BITS +:
                             cpu_pkg::DCACHE_INDEX_BITS];
   assign req_tag   = addr_i[cpu_pkg::BUS_ADDRESS_WIDTH-1 -: cpu_pkg::DCACHE_TAG_BITS];
   assign req_word  = addr_i[cpu_pkg::BUS_DATA_WIDTH_SHIFT-1:2];

   assign store_req  = (write_en_i == 4'hf);
   assign req_valid  = (state_q == cpu_pkg::DC_IDLE) && (read_en_i || store_req);
   assign hit        = valid_q[req_index] && (tags_q[req_index] == req_tag);
   assign fill_done  = (state_q == cpu_pkg::DC_FILL) && bus_valid_i;
   assign hit_line   = lines_q[req_index];
   assign hit_merged = merge_word(hit_line, req_word, data_i);
   assign fill_line  = req_store_q ? merge_word(bus_data_i, req_word_q, req_data_q) : bus_data_i;

   assign blocking_n_o = (state_q == cpu_pkg::DC_IDLE) || (state_q == cpu_pkg::DC_DONE);

   // bus strobes and line valid bits
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= cpu_pkg::DC_IDLE;
         valid_q     <= '0;
         bus_valid_o <= 1'b0;
         bus_we_o    <= 1'b0;
      end else begin
         bus_valid_o <= 1'b0;
         case (state_q)
            cpu_pkg::DC_IDLE: begin
               // stores always go out, loads only on a miss
               if (req_valid && (store_req || !hit)) begin
                  bus_valid_o <= 1'b1;
                  bus_we_o    <= store_req && hit;
                  state_q     <= (store_req && hit) ? cpu_pkg::DC_WRITE : cpu_pkg::DC_FILL;
               end
            end
            cpu_pkg::DC_FILL: begin
               if (bus_valid_i) begin
                  valid_q[req_index_q] <= 1'b1;
                  if (req_store_q) begin
                     bus_valid_o <= 1'b1;
                     bus_we_o    <= 1'b1;
                     state_q     <= cpu_pkg::DC_WRITE;
                  end else begin
                     state_q <= cpu_pkg::DC_DONE;
                  end
               end
            end
            cpu_pkg::DC_WRITE: begin
               if (bus_valid_i) begin
                  bus_we_o <= 1'b0;
                  state_q  <= cpu_pkg::DC_DONE;
               end
            end
            default: state_q <= cpu_pkg::DC_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid) begin
         req_index_q <= req_index;
         req_tag_q   <= req_tag;
         req_word_q  <= req_word;
         req_data_q  <= data_i;
         req_store_q <= store_req;
         bus_addr_o  <= addr_i[cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT];
         data_o      <= hit_line[req_word*32 +: 32];
         if (store_req && hit) begin
            lines_q[req_index] <= hit_merged;
            bus_data_o         <= hit_merged;
         end
      end
      // a store miss merges its word into the fetched line before writing it back
      if (fill_done) begin
         lines_q[req_index_q] <= fill_line;
         tags_q[req_index_q]  <= req_tag_q;
         bus_data_o           <= fill_line;
         data_o               <= bus_data_i[req_word_q*32 +: 32];
      end
   end

endmodule

// ==== design/internal_rom.sv ====
`timescale 1ns/10ps

module internal_rom (
   input  logic [cpu_pkg::ROM_DEPTH_BITS-1:0] address_i,
   output logic [31:0]                        data_o
);

   cpu_pkg::instr_u word;

   always_comb begin
      case (address_i)
         // lw x1, 0x10(x0) and lw x2, 0x14(x0), same line
         5'd0: word.i_fmt = '{12'h010, 5'd0, 3'b010, 5'd1, cpu_pkg::OP_LOAD};
         5'd1: word.i_fmt = '{12'h014, 5'd0, 3'b010, 5'd2, cpu_pkg::OP_LOAD};
         // add x3, x1, x2 then sw x3, 0x18(x0)
         5'd2: word.r_fmt = '{7'h00, 5'd2, 5'd1, 3'b000, 5'd3, cpu_pkg::OP_OP};
         5'd3: word.s_fmt = '{7'h00, 5'd3, 5'd0, 3'b010, 5'h18, cpu_pkg::OP_STORE};
         // x4 = 0x5a5a0123, stored to 0x40 which evicts line 0x001
         5'd4: word.u_fmt = '{20'h5a5a0, 5'd4, cpu_pkg::OP_LUI};
         5'd5: word.i_fmt = '{12'h123, 5'd4, 3'b000, 5'd4, cpu_pkg::OP_OP_IMM};
         5'd6: word.s_fmt = '{7'h02, 5'd4, 5'd0, 3'b010, 5'h00, cpu_pkg::OP_STORE};
         // reload 0x10 and copy it to 0x1c
         5'd7: word.i_fmt = '{12'h010, 5'd0, 3'b010, 5'd5, cpu_pkg::OP_LOAD};
         5'd8: word.s_fmt = '{7'h00, 5'd5, 5'd0, 3'b010, 5'h1c, cpu_pkg::OP_STORE};
         // sub x6, x5, x1 is zero when the reload matches, beq then jumps +16
         5'd9:  word.r_fmt = '{7'h20, 5'd1, 5'd5, 3'b000, 5'd6, cpu_pkg::OP_OP};
         5'd10: word.s_fmt = '{7'h00, 5'd0, 5'd6, 3'b000, 5'b10000, cpu_pkg::OP_BRANCH};
         // skipped: x7 = 0x1000 - 0x453 = 0xbad, sw x7, 0x44(x0)
         5'd11: word.u_fmt = '{20'h00001, 5'd7, cpu_pkg::OP_LUI};
         5'd12: word.i_fmt = '{12'hbad, 5'd7, 3'b000, 5'd7, cpu_pkg::OP_OP_IMM};
         5'd13: word.s_fmt = '{7'h02, 5'd7, 5'd0, 3'b010, 5'h04, cpu_pkg::OP_STORE};
         // jal x0, 0 holds the core here
         default: word.u_fmt = '{20'h00000, 5'd0, cpu_pkg::OP_JAL};
      endcase
   end

   assign data_o = word;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [4:0]  rs1_i,
   input  logic [4:0]  rs2_i,
   input  logic [4:0]  rd_i,
   input  logic [31:0] rd_data_i,
   input  logic        rd_we_i,
   output logic [31:0] rs1_data_o,
   output logic [31:0] rs2_data_o
);

   logic [31:0] regs_q [32];

   // x0 is cleared by reset and never written, so it always reads zero
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < 32; i++) begin
            regs_q[i] <= 32'd0;
         end
      end else if (rd_we_i && rd_i != 5'd0) begin
         regs_q[rd_i] <= rd_data_i;
      end
   end

   assign rs1_data_o = regs_q[rs1_i];
   assign rs2_data_o = regs_q[rs2_i];

endmodule

// ==== verif/bus_memory_model.sv ====
`timescale 1ns/10ps

module bus_memory_model (
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic [19:4]  bus_addr_i,
   input  logic [127:0] bus_data_i,
   input  logic         bus_we_i,
   input  logic         bus_valid_i,
   output logic [127:0] bus_data_o,
   output logic         bus_valid_o
);

   logic [127:0] lines [64];
   logic [5:0]   index_q;
   logic         we_q;
   logic [127:0] wdata_q;
   logic [1:0]   count_q;
   logic         busy_q  = 1'b0;
   logic         valid_q = 1'b0;
   logic [127:0] rdata_q = '0;
   integer       seed = 32'hdc32;
   integer       rnd;
   int           write_count = 0;

   // every word holds a tag plus its own byte address, except the two preloaded words
   initial begin
      for (int ln = 0; ln < 64; ln++) begin
         for (int w = 0; w < 4; w++) begin
            lines[ln][w*32 +: 32] = 32'hc0de0000 | (ln * 16 + w * 4);
         end
      end
      lines[1][31:0]  = 32'h00000011;
      lines[1][63:32] = 32'h00000007;
   end

   // one request at a time, answered 1 to 4 cycles after it is taken
   always @(posedge clk_i) begin
      valid_q <= 1'b0;
      if (rst_i) begin
         busy_q <= 1'b0;
      end else if (busy_q) begin
         if (count_q == 2'd0) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b1;
            if (we_q) begin
               lines[index_q] <= wdata_q;
               write_count    <= write_count + 1;
            end else begin
               rdata_q <= lines[index_q];
            end
         end else begin
            count_q <= count_q - 2'd1;
         end
      end else if (bus_valid_i) begin
         rnd = $random(seed);
         busy_q  <= 1'b1;
         count_q <= rnd[1:0];
         index_q <= bus_addr_i[9:4];
         we_q    <= bus_we_i;
         wdata_q <= bus_data_i;
      end
   end

   assign bus_valid_o = valid_q;
   assign bus_data_o  = rdata_q;

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

   localparam int NUM_TXN      = 6;
   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int QUIET_CYCLES = 64;

   logic         clk = 1'b0;
   logic         rst = 1'b1;
   logic [19:4]  bus_addr;
   logic [127:0] bus_wdata;
   logic         bus_we;
   logic         bus_valid;
   logic [127:0] bus_rdata;
   logic         bus_ack;

   // expected bus transactions in program order
   logic         exp_we   [$];
   logic [19:4]  exp_addr [$];
   logic [127:0] exp_data [$];

   // transactions seen on the bus
   logic         rec_we   [$];
   logic [19:4]  rec_addr [$];
   logic [127:0] rec_data [$];
   time          rec_time [$];
   int           rec_count = 0;

   logic         pending = 1'b0;
   logic         held_we;
   logic [19:4]  held_addr;
   logic [127:0] held_data;
   int           hold_errors = 0;
   int           test_errors = 0;
   int           tests_ok = 0;
   int           tests_bad = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   cpu dut0 (
      .clk_i       (clk),
      .rst_i       (rst),
      .bus_addr_o  (bus_addr),
      .bus_data_o  (bus_wdata),
      .bus_we_o    (bus_we),
      .bus_valid_o (bus_valid),
      .bus_data_i  (bus_rdata),
      .bus_valid_i (bus_ack)
   );

   bus_memory_model mem0 (
      .clk_i       (clk),
      .rst_i       (rst),
      .bus_addr_i  (bus_addr),
      .bus_data_i  (bus_wdata),
      .bus_we_i    (bus_we),
      .bus_valid_i (bus_valid),
      .bus_data_o  (bus_rdata),
      .bus_valid_o (bus_ack)
   );

   task automatic add_expected(input logic we, input logic [19:4] addr, input logic [127:0] data);
      exp_we.push_back(we);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic check_bus_idle();
      if (bus_valid !== 1'b0) begin
         $display("[FAIL] %0t bus_valid_o expected 0 got %b", $time, bus_valid);
         test_errors++;
      end
      if (bus_we !== 1'b0) begin
         $display("[FAIL] %0t bus_we_o expected 0 got %b", $time, bus_we);
         test_errors++;
      end
   endtask

   task automatic report_test(input string name, input int fails);
      if (fails == 0) begin
         $display("%s: ok", name);
         tests_ok++;
      end else begin
         $display("%s: FAILED with %0d errors", name, fails);
         tests_bad++;
      end
   endtask

   // bus monitor, also checks that a request is held until the memory answers
   always @(posedge clk) begin
      if (!rst && bus_valid) begin
         if (pending) begin
            $display("error at %0t: new bus request while one is still outstanding", $time);
            hold_errors++;
         end
         rec_we.push_back(bus_we);
         rec_addr.push_back(bus_addr);
         rec_data.push_back(bus_wdata);
         rec_time.push_back($time);
         rec_count++;
         pending   = 1'b1;
         held_we   = bus_we;
         held_addr = bus_addr;
         held_data = bus_wdata;
      end else if (pending) begin
         if (bus_addr !== held_addr) begin
            $display("[FAIL] %0t bus_addr_o expected %h got %h", $time, held_addr, bus_addr);
            hold_errors++;
         end
         if (bus_wdata !== held_data) begin
            $display("[FAIL] %0t bus_data_o expected %h got %h", $time, held_data, bus_wdata);
            hold_errors++;
         end
         if (bus_we !== held_we) begin
            $display("[FAIL] %0t bus_we_o expected %b got %b", $time, held_we, bus_we);
            hold_errors++;
         end
         if (bus_ack) begin
            pending = 1'b0;
         end
      end else if (!rst && bus_ack) begin
         $display("error at %0t: memory answered with no request outstanding", $time);
         hold_errors++;
      end
   end

   initial begin
      int    num_writes;
      string name;

      // line data is word 3 down to word 0
      add_expected(1'b0, 16'h0001, '0);
      add_expected(1'b1, 16'h0001, {32'hc0de001c, 32'h00000018, 32'h00000007, 32'h00000011});
      add_expected(1'b0, 16'h0004, '0);
      add_expected(1'b1, 16'h0004, {32'hc0de004c, 32'hc0de0048, 32'hc0de0044, 32'h5a5a0123});
      add_expected(1'b0, 16'h0001, '0);
      add_expected(1'b1, 16'h0001, {32'h00000011, 32'h00000018, 32'h00000007, 32'h00000011});

      // first edge still samples the unreset outputs
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk);
         if (i > 0) begin
            check_bus_idle();
         end
      end
      rst <= 1'b0;
      repeat (2) begin
         @(posedge clk);
         check_bus_idle();
      end
      report_test("bus idle through reset", test_errors);

      for (int t = 0; t < NUM_TXN; t++) begin
         test_errors = 0;
         wait (rec_count > t);
         if (rec_we[t] !== exp_we[t]) begin
            $display("[FAIL] %0t bus_we_o expected %b got %b", rec_time[t], exp_we[t], rec_we[t]);
            test_errors++;
         end
         if (rec_addr[t] !== exp_addr[t]) begin
            $display("[FAIL] %0t bus_addr_o expected %h got %h",
                     rec_time[t], exp_addr[t], rec_addr[t]);
            test_errors++;
         end
         if (exp_we[t] && rec_data[t] !== exp_data[t]) begin
            $display("[FAIL] %0t bus_data_o expected %h got %h",
                     rec_time[t], exp_data[t], rec_data[t]);
            test_errors++;
         end
         name = $sformatf("transaction %0d, %s line %h", t, exp_we[t] ? "write" : "read",
                          exp_addr[t]);
         report_test(name, test_errors);
      end

      // let the core sit in its idle loop
      wait (!pending);
      repeat (QUIET_CYCLES) @(posedge clk);

      test_errors = 0;
      num_writes = 0;
      for (int t = 0; t < NUM_TXN; t++) begin
         if (exp_we[t]) begin
            num_writes++;
         end
      end
      if (rec_count != NUM_TXN) begin
         $display("error: %0d bus transactions seen after the program idled, %0d expected",
                  rec_count, NUM_TXN);
         test_errors++;
      end
      if (mem0.write_count != num_writes) begin
         $display("error: memory took %0d line writes, %0d expected", mem0.write_count,
                  num_writes);
         test_errors++;
      end
      report_test("no traffic after the final write", test_errors);

      test_errors = 0;
      for (int t = 0; t < rec_count; t++) begin
         if (rec_we[t] && rec_addr[t] == 16'h0004 && rec_data[t][63:32] == 32'h00000bad) begin
            $display("error: store of 0xbad to 0x00044 reached the bus at %0t", rec_time[t]);
            test_errors++;
         end
      end
      report_test("beq skips the store of 0xbad", test_errors);

      report_test("bus request held until acknowledge", hold_errors);

      $display("summary: %0d ok, %0d failing", tests_ok, tests_bad);
      if (tests_bad == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // run limit scales with the number of expected transactions
   initial begin
      #(NUM_TXN * 40 * CLK_PERIOD);
      $display("timeout waiting for bus transaction");
      $display("Test failed");
      $finish;
   end

endmodule
